// ==== rtl/gf_field_pkg.sv ====
`default_nettype none

package gf_field_pkg;

	// ==================================================
	// Field GF(2^7), trinomial x^7 + x + 1
	// ==================================================

	localparam int gf_m = 7;                   // Field degree.
	localparam int gf_order = (1 << gf_m) - 1; // Multiplicative order of alpha.

	typedef logic [gf_m-1:0] gf_elem_t;
	typedef logic [gf_m-1:0][gf_m-1:0] gf_mat_t; // One element per row.

	localparam gf_elem_t gf_poly = gf_elem_t'(3); // x + 1, x^7 implied.

	// LFSR cycle counter, x^3 + x + 1.
	localparam int gf_cnt_w = 3;
	typedef logic [gf_cnt_w-1:0] gf_cnt_t;
	localparam gf_cnt_t gf_cnt_poly = gf_cnt_t'(3);

	function automatic gf_elem_t gf_mul1(input gf_elem_t x);
		return {x[gf_m-2:0], 1'b0} ^ ({gf_m{x[gf_m-1]}} & gf_poly);
	endfunction

	function automatic gf_elem_t gf_lpow(input int i);
		gf_elem_t r;
		r = gf_elem_t'(1);
		for (int k = 0; k < i % gf_order; k++) begin
			r = gf_mul1(r);
		end
		return r;
	endfunction

	// Dual coordinates use the functional z -> z[0], so d_i = coef0(z * alpha^i).
	function automatic gf_elem_t gf_to_dual_row(input int i);
		gf_elem_t row;
		gf_elem_t pw;
		row = '0;
		for (int j = 0; j < gf_m; j++) begin
			pw = gf_lpow(i + j);
			row[j] = pw[0];
		end
		return row;
	endfunction

	function automatic gf_elem_t gf_std_to_dual(input gf_elem_t x);
		gf_elem_t d;
		for (int i = 0; i < gf_m; i++) begin
			d[i] = ^(gf_to_dual_row(i) & x);
		end
		return d;
	endfunction

	// Gauss-Jordan over GF(2) on the standard-to-dual rows.
	function automatic gf_mat_t gf_dual_to_std_mat();
		gf_mat_t a;
		gf_mat_t inv;
		gf_elem_t tmp;
		int p;
		for (int i = 0; i < gf_m; i++) begin
			a[i] = gf_to_dual_row(i);
			inv[i] = gf_elem_t'(1) << i;
		end
		for (int c = 0; c < gf_m; c++) begin
			p = c;
			while (p < gf_m - 1 && !a[p][c]) begin
				p++;
			end
			tmp = a[c];
			a[c] = a[p];
			a[p] = tmp;
			tmp = inv[c];
			inv[c] = inv[p];
			inv[p] = tmp;
			for (int r = 0; r < gf_m; r++) begin
				if (r != c && a[r][c]) begin
					a[r] ^= a[c];
					inv[r] ^= inv[c];
				end
			end
		end
		return inv;
	endfunction

	function automatic gf_cnt_t gf_cnt_next(input gf_cnt_t c);
		return {c[gf_cnt_w-2:0], 1'b0} ^ ({gf_cnt_w{c[gf_cnt_w-1]}} & gf_cnt_poly);
	endfunction

	function automatic gf_cnt_t gf_cnt_after(input int n);
		gf_cnt_t c;
		c = gf_cnt_t'(1);
		for (int k = 0; k < n; k++) begin
			c = gf_cnt_next(c);
		end
		return c;
	endfunction

	localparam gf_elem_t gf_one_dual = gf_std_to_dual(gf_elem_t'(1)); // One, dual basis.
	localparam gf_mat_t gf_from_dual = gf_dual_to_std_mat();         // Row j gives bit j.
	localparam gf_cnt_t gf_cnt_last = gf_cnt_after(gf_m - 1);

endpackage

`default_nettype wire

// ==== rtl/gf_op_pkg.sv ====
`default_nettype none

package gf_op_pkg;

	// ==================================================
	// Command and result formats
	// ==================================================

	localparam int gf_op_w = 3;

	typedef enum logic [gf_op_w-1:0] {
		op_mul  = 3'd0, // Bit-parallel a*b.
		op_sqr  = 3'd1, // a^2.
		op_cube = 3'd2, // a^3.
		op_smul = 3'd3, // Bit-serial a*b.
		op_div  = 3'd4  // a/b by Fermat inversion.
	} gf_op_t;

	typedef struct packed {
		gf_op_t op;
		gf_field_pkg::gf_elem_t a; // Numerator for op_div.
		gf_field_pkg::gf_elem_t b; // Denominator for op_div.
	} gf_cmd_t;

	typedef struct packed {
		gf_field_pkg::gf_elem_t value;
		logic div_zero; // Set when op_div had b = 0.
	} gf_result_t;

endpackage

`default_nettype wire

// ==== rtl/gf_standard_mult.sv ====
`default_nettype none
`timescale 1ns/10ps

// Bit-parallel standard-basis multiplier in PPBML form.
module gf_standard_mult (
	input  wire gf_field_pkg::gf_elem_t a,
	input  wire gf_field_pkg::gf_elem_t b,
	output gf_field_pkg::gf_elem_t p
);

	gf_field_pkg::gf_mat_t z; // Row i holds bit i of every block.

	// Stage 1, block j is alpha^j * a.
	always_comb begin
		gf_field_pkg::gf_elem_t blk;
		blk = a;
		for (int j = 0; j < gf_field_pkg::gf_m; j++) begin
			for (int i = 0; i < gf_field_pkg::gf_m; i++) begin
				z[i][j] = blk[i]; // Rearrange into output rows.
			end
			blk = gf_field_pkg::gf_mul1(blk);
		end
	end

	// Stage 2, each product bit is a parity against b.
	always_comb begin
		for (int i = 0; i < gf_field_pkg::gf_m; i++) begin
			p[i] = ^(z[i] & b);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/gf_power.sv ====
`default_nettype none
`timescale 1ns/10ps

// Square and cube of a standard-basis element.
module gf_power (
	input  wire gf_field_pkg::gf_elem_t x,
	output gf_field_pkg::gf_elem_t sq,
	output gf_field_pkg::gf_elem_t cube
);

	// Squaring is linear, bit j of x lands on column alpha^(2j).
	always_comb begin
		sq = '0;
		for (int j = 0; j < gf_field_pkg::gf_m; j++) begin
			sq ^= {gf_field_pkg::gf_m{x[j]}} & gf_field_pkg::gf_lpow(2 * j);
		end
	end

	// ==================================================
	// Cube as first term plus cross terms
	// ==================================================
	// x^3 = sum x_i alpha^(3i) + sum(i<j) x_i x_j (alpha^(2i+j) + alpha^(i+2j))
	always_comb begin
		cube = '0;
		for (int i = 0; i < gf_field_pkg::gf_m; i++) begin
			cube ^= {gf_field_pkg::gf_m{x[i]}} & gf_field_pkg::gf_lpow(3 * i);
			for (int j = i + 1; j < gf_field_pkg::gf_m; j++) begin
				cube ^= {gf_field_pkg::gf_m{x[i] & x[j]}} &
					(gf_field_pkg::gf_lpow(2 * i + j) ^ gf_field_pkg::gf_lpow(i + 2 * j));
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/gf_dual_mult.sv ====
`default_nettype none
`timescale 1ns/10ps

// Berlekamp multiplier, dual operand times standard operand gives dual product.
module gf_dual_mult (
	input  wire gf_field_pkg::gf_elem_t dual_a,
	input  wire gf_field_pkg::gf_elem_t std_b,
	output gf_field_pkg::gf_elem_t dual_p
);

	// Dual coordinates d_0 .. d_(2m-2), upper m-1 are auxiliary terms.
	logic [2*gf_field_pkg::gf_m-2:0] ext;

	// ==================================================
	// Auxiliary terms from the field LFSR
	// ==================================================
	always_comb begin
		ext = '0;
		ext[gf_field_pkg::gf_m-1:0] = dual_a;
		for (int k = gf_field_pkg::gf_m; k < 2 * gf_field_pkg::gf_m - 1; k++) begin
			// d_k follows alpha^m = poly taps.
			ext[k] = ^(ext[k-gf_field_pkg::gf_m +: gf_field_pkg::gf_m] & gf_field_pkg::gf_poly);
		end
	end

	// Each output bit is a sliding window of the extended vector against b.
	always_comb begin
		for (int i = 0; i < gf_field_pkg::gf_m; i++) begin
			dual_p[i] = ^(ext[i +: gf_field_pkg::gf_m] & std_b);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/gf_serial_mult.sv ====
`default_nettype none
`timescale 1ns/10ps

// MSB-first bit-serial standard-basis multiplier.
module gf_serial_mult (
	input  wire clk,
	input  wire reset,
	input  wire start,
	input  wire gf_field_pkg::gf_elem_t a,
	input  wire gf_field_pkg::gf_elem_t b,
	output gf_field_pkg::gf_elem_t p,
	output logic fin
);

	gf_field_pkg::gf_elem_t a_sh;  // Bits of a still to come, MSB first.
	gf_field_pkg::gf_elem_t b_q;
	gf_field_pkg::gf_elem_t term;
	gf_field_pkg::gf_cnt_t cnt;    // Bits left after the current one.

	// Start cycle folds in the top bit of a straight from the port.
	assign term = start ? ({gf_field_pkg::gf_m{a[gf_field_pkg::gf_m-1]}} & b) :
		({gf_field_pkg::gf_m{a_sh[gf_field_pkg::gf_m-1]}} & b_q);

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			fin <= 1'b0;
		end else begin
			fin <= (cnt == gf_field_pkg::gf_cnt_t'(1)); // Last bit this cycle.
			if (start) begin
				cnt <= gf_field_pkg::gf_cnt_t'(gf_field_pkg::gf_m - 1);
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// Horner step, acc = acc * alpha + a_i * b.
	always_ff @(posedge clk) begin
		if (start) begin
			a_sh <= {a[gf_field_pkg::gf_m-2:0], 1'b0};
			b_q <= b;
			p <= term;
		end else if (cnt != '0) begin
			a_sh <= a_sh << 1;
			p <= gf_field_pkg::gf_mul1(p) ^ term;
		end
	end

	assert property (@(posedge clk) disable iff (reset) fin |=> !fin)
		else $error("serial multiplier fin held for two cycles");

endmodule

`default_nettype wire

// ==== rtl/gf_divider.sv ====
`default_nettype none
`timescale 1ns/10ps

// Fermat divider, numer * denom^(2^m - 2) with the inverse accumulated in dual form.
module gf_divider (
	input  wire clk,
	input  wire reset,
	input  wire start,
	input  wire gf_field_pkg::gf_elem_t numer,
	input  wire gf_field_pkg::gf_elem_t denom,
	output gf_field_pkg::gf_elem_t quot,
	output logic fin
);

	gf_field_pkg::gf_elem_t pw_q;    // Last square of the denominator.
	gf_field_pkg::gf_elem_t pw_in;
	gf_field_pkg::gf_elem_t pw_sq;
	gf_field_pkg::gf_elem_t acc_q;   // Product of squares, dual basis.
	gf_field_pkg::gf_elem_t acc_in;
	gf_field_pkg::gf_elem_t acc_d;
	gf_field_pkg::gf_elem_t mul_b;
	gf_field_pkg::gf_elem_t numer_q;
	gf_field_pkg::gf_elem_t quot_d;
	gf_field_pkg::gf_cnt_t cnt;      // Sits at 1 when idle.
	logic run;
	logic last;

	assign last = run && (cnt == gf_field_pkg::gf_cnt_last);

	// ==================================================
	// Square and accumulate
	// ==================================================
	assign pw_in = start ? denom : pw_q;

	gf_power u_sq (
		.x(pw_in),
		.sq(pw_sq),
		.cube()
	);

	assign acc_in = start ? gf_field_pkg::gf_one_dual : acc_q; // Product restarts at one.
	assign mul_b = last ? numer_q : pw_sq;                       // Final pass takes numerator.

	gf_dual_mult u_acc (
		.dual_a(acc_in),
		.std_b(mul_b),
		.dual_p(acc_d)
	);

	// Dual quotient back to standard basis.
	always_comb begin
		for (int j = 0; j < gf_field_pkg::gf_m; j++) begin
			quot_d[j] = ^(gf_field_pkg::gf_from_dual[j] & acc_d);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
			fin <= 1'b0;
			cnt <= gf_field_pkg::gf_cnt_t'(1);
		end else begin
			fin <= last;
			if (start) begin
				run <= 1'b1;
			end else if (last) begin
				run <= 1'b0;
			end
			if (start || run) begin
				cnt <= last ? gf_field_pkg::gf_cnt_t'(1) : gf_field_pkg::gf_cnt_next(cnt);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start || run) begin
			pw_q <= pw_sq;
			acc_q <= acc_d;
		end
		if (start) begin
			numer_q <= numer;
		end
		if (last) begin
			quot <= quot_d;
		end
	end

	// The top level holds off new divisions until fin.
	assert property (@(posedge clk) disable iff (reset) start |-> !run)
		else $error("divider started while running");

endmodule

`default_nettype wire

// ==== rtl/gf_alu.sv ====
`default_nettype none
`timescale 1ns/10ps

// GF(2^7) arithmetic unit, one command at a time.
module gf_alu (
	input  wire clk,
	input  wire reset,
	input  wire cmd_valid,
	input  wire gf_op_pkg::gf_cmd_t cmd,
	output logic busy,
	output logic done,
	output gf_op_pkg::gf_result_t result
);

	logic accept;
	logic comb_op;   // Result ready from combinational logic.
	logic unit_op;   // Needs the serial multiplier or the divider.
	logic smul_start;
	logic div_start;
	logic smul_fin;
	logic div_fin;
	logic unit_fin;
	logic pend_zero; // Division by zero in flight.
	gf_op_pkg::gf_op_t pend_op;
	gf_field_pkg::gf_elem_t mul_p;
	gf_field_pkg::gf_elem_t sq_p;
	gf_field_pkg::gf_elem_t cube_p;
	gf_field_pkg::gf_elem_t smul_p;
	gf_field_pkg::gf_elem_t div_q;
	gf_field_pkg::gf_elem_t comb_val;
	gf_field_pkg::gf_elem_t unit_val;

	// ==================================================
	// Decode
	// ==================================================
	assign accept = cmd_valid && !busy;

	always_comb begin
		comb_op = 1'b1;
		unit_op = 1'b0;
		comb_val = mul_p;
		case (cmd.op)
			gf_op_pkg::op_mul: comb_val = mul_p;
			gf_op_pkg::op_sqr: comb_val = sq_p;
			gf_op_pkg::op_cube: comb_val = cube_p;
			gf_op_pkg::op_smul, gf_op_pkg::op_div: begin
				comb_op = 1'b0;
				unit_op = 1'b1;
			end
			default: comb_op = 1'b0; // Unused codes are dropped.
		endcase
	end

	assign smul_start = accept && (cmd.op == gf_op_pkg::op_smul);
	assign div_start = accept && (cmd.op == gf_op_pkg::op_div);

	gf_standard_mult u_mul (
		.a(cmd.a),
		.b(cmd.b),
		.p(mul_p)
	);

	gf_power u_pow (
		.x(cmd.a),
		.sq(sq_p),
		.cube(cube_p)
	);

	gf_serial_mult u_smul (
		.clk(clk),
		.reset(reset),
		.start(smul_start),
		.a(cmd.a),
		.b(cmd.b),
		.p(smul_p),
		.fin(smul_fin)
	);

	gf_divider u_div (
		.clk(clk),
		.reset(reset),
		.start(div_start),
		.numer(cmd.a),
		.denom(cmd.b),
		.quot(div_q),
		.fin(div_fin)
	);

	assign unit_fin = (pend_op == gf_op_pkg::op_div) ? div_fin : smul_fin;
	assign unit_val = (pend_op == gf_op_pkg::op_div) ? div_q : smul_p;

	// ==================================================
	// Busy, done and result
	// ==================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			result <= '0;
			pend_op <= gf_op_pkg::op_mul;
			pend_zero <= 1'b0;
		end else begin
			done <= 1'b0;
			if (accept && comb_op) begin
				done <= 1'b1;
				result.value <= comb_val;
				result.div_zero <= 1'b0;
			end else if (accept && unit_op) begin
				busy <= 1'b1;
				pend_op <= cmd.op;
				pend_zero <= (cmd.op == gf_op_pkg::op_div) && (cmd.b == '0); // b tested once.
			end else if (busy && unit_fin) begin
				busy <= 1'b0; // Falls with done.
				done <= 1'b1;
				result.value <= unit_val;
				result.div_zero <= pend_zero;
			end
		end
	end

	// Only the selected unit may finish, and only while busy.
	assert property (@(posedge clk) disable iff (reset)
		(smul_fin || div_fin) |-> busy && (smul_fin != div_fin) &&
			(div_fin == (pend_op == gf_op_pkg::op_div)))
		else $error("fin from a unit that was not selected");

endmodule

`default_nettype wire

// ==== dv/gf_model.svh ====
`ifndef GF_MODEL_SVH
`define GF_MODEL_SVH

// ==================================================
// Software model of GF(2^7)
// ==================================================

// Shift-and-add product, b scanned LSB first.
function automatic gf_field_pkg::gf_elem_t mul_ref(
	input gf_field_pkg::gf_elem_t a,
	input gf_field_pkg::gf_elem_t b
);
	gf_field_pkg::gf_elem_t r;
	gf_field_pkg::gf_elem_t sh;
	logic carry;
	r = '0;
	sh = a;
	for (int i = 0; i < gf_field_pkg::gf_m; i++) begin
		if (b[i]) begin
			r ^= sh;
		end
		carry = sh[gf_field_pkg::gf_m-1];
		sh = sh << 1;
		if (carry) begin
			sh ^= gf_field_pkg::gf_poly; // x^7 = x + 1.
		end
	end
	return r;
endfunction

// Square and multiply.
function automatic gf_field_pkg::gf_elem_t pow_ref(input gf_field_pkg::gf_elem_t x, input int e);
	gf_field_pkg::gf_elem_t r;
	gf_field_pkg::gf_elem_t base;
	int k;
	r = gf_field_pkg::gf_elem_t'(1);
	base = x;
	k = e;
	while (k > 0) begin
		if (k[0]) begin
			r = mul_ref(r, base);
		end
		base = mul_ref(base, base);
		k = k >> 1;
	end
	return r;
endfunction

function automatic gf_field_pkg::gf_elem_t inv_ref(input gf_field_pkg::gf_elem_t x);
	return pow_ref(x, (1 << gf_field_pkg::gf_m) - 2); // Zero maps to zero.
endfunction

function automatic logic is_unit_op(input gf_op_pkg::gf_op_t op);
	return (op == gf_op_pkg::op_smul) || (op == gf_op_pkg::op_div);
endfunction

// Edges from the accepting edge to the sample that sees done.
function automatic int latency_of(input gf_op_pkg::gf_op_t op);
	return is_unit_op(op) ? gf_field_pkg::gf_m + 1 : 1;
endfunction

function automatic gf_field_pkg::gf_elem_t expected_value(
	input gf_op_pkg::gf_op_t op,
	input gf_field_pkg::gf_elem_t a,
	input gf_field_pkg::gf_elem_t b
);
	case (op)
		gf_op_pkg::op_mul: return mul_ref(a, b);
		gf_op_pkg::op_sqr: return pow_ref(a, 2);
		gf_op_pkg::op_cube: return pow_ref(a, 3);
		gf_op_pkg::op_smul: return mul_ref(a, b);
		gf_op_pkg::op_div: return mul_ref(a, inv_ref(b));
		default: return '0;
	endcase
endfunction

`endif

// ==== dv/gf_alu_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module gf_alu_tb;

	localparam int clk_period = 8;
	localparam int reset_cycles = 16;
	localparam int n_rand = 40;                         // Random commands per op.
	localparam int n_special = 4;                       // Zero divisors and busy cases.
	localparam int n_cmds = 6 * n_rand + 2 * n_special;
	localparam int watchdog_cycles = n_cmds * 10 + reset_cycles;
	localparam int done_limit = 2 * (gf_field_pkg::gf_m + 1);

	logic clk;
	logic reset;
	logic cmd_valid;
	gf_op_pkg::gf_cmd_t cmd;
	logic busy;
	logic done;
	gf_op_pkg::gf_result_t result;

	int seed;
	int errors;
	int test_errors;
	int pass_count;
	int fail_count;
	int age;                            // Edges since the command was taken.
	int exp_lat;
	logic started;
	logic expect_done;
	logic chk_div;                      // Non-zero divisor in flight.
	logic exp_zero;
	gf_field_pkg::gf_elem_t exp_value;
	gf_field_pkg::gf_elem_t cur_a;
	gf_field_pkg::gf_elem_t cur_b;

	`include "gf_model.svh"

	gf_alu dut0 (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.busy(busy),
		.done(done),
		.result(result)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			age <= 0;
		end else if (cmd_valid && !busy) begin
			age <= 1; // Accepting edge.
		end else if (done) begin
			age <= 0;
		end else if (age != 0) begin
			age <= age + 1;
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	assert property (@(posedge clk) disable iff (reset)
		!started |-> !busy && !done && result == '0)
		else begin
			errors++;
			$display("** Error: %0d ns: outputs not idle after reset", $time);
		end

	assert property (@(posedge clk) disable iff (reset) done |-> age == exp_lat && !busy)
		else begin
			errors++;
			$display("** Error: %0d ns: done after %0d cycles, expected %0d", $time, age, exp_lat);
		end

	assert property (@(posedge clk) disable iff (reset)
		(age != 0 && age < exp_lat) |-> busy && !done)
		else begin
			errors++;
			$display("** Error: %0d ns: busy low or early done at cycle %0d", $time, age);
		end

	assert property (@(posedge clk) disable iff (reset) done |-> expect_done)
		else begin
			errors++;
			$display("** Error: %0d ns: done without a taken command", $time);
		end

	assert property (@(posedge clk) disable iff (reset) done |-> result.value == exp_value)
		else begin
			errors++;
			$display("** Error: %0d ns: value %h, expected %h (a %h, b %h)",
				$time, result.value, exp_value, cur_a, cur_b);
		end

	assert property (@(posedge clk) disable iff (reset) done |-> result.div_zero == exp_zero)
		else begin
			errors++;
			$display("** Error: %0d ns: div_zero %b, expected %b", $time, result.div_zero, exp_zero);
		end

	assert property (@(posedge clk) disable iff (reset)
		(done && chk_div) |-> mul_ref(result.value, cur_b) == cur_a)
		else begin
			errors++;
			$display("** Error: %0d ns: quotient %h times %h does not give %h",
				$time, result.value, cur_b, cur_a);
		end

	// ==================================================
	// Stimulus
	// ==================================================
	function automatic gf_field_pkg::gf_elem_t rand_elem();
		return gf_field_pkg::gf_elem_t'($random(seed));
	endfunction

	task automatic send_cmd(input gf_op_pkg::gf_op_t op, input gf_field_pkg::gf_elem_t a,
		input gf_field_pkg::gf_elem_t b);
		exp_value = expected_value(op, a, b);
		exp_zero = (op == gf_op_pkg::op_div) && (b == '0);
		chk_div = (op == gf_op_pkg::op_div) && (b != '0);
		exp_lat = latency_of(op);
		cur_a = a;
		cur_b = b;
		expect_done = 1'b1;
		started = 1'b1;
		cmd_valid = 1'b1;
		cmd.op = op;
		cmd.a = a;
		cmd.b = b;
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	task automatic wait_for_done();
		int n;
		n = 0;
		while (!done && n < done_limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!done) begin
			errors++;
			$display("No done within %0d cycles, command at %0d ns was lost", done_limit, $time);
		end
		@(posedge clk); // Checks sample the pulse here.
		#1;
		expect_done = 1'b0;
	endtask

	task automatic run_cmd(input gf_op_pkg::gf_op_t op, input gf_field_pkg::gf_elem_t a,
		input gf_field_pkg::gf_elem_t b);
		send_cmd(op, a, b);
		wait_for_done();
	endtask

	// A second command lands in the middle of the busy window.
	task automatic run_with_stray(input gf_op_pkg::gf_op_t op, input gf_field_pkg::gf_elem_t a,
		input gf_field_pkg::gf_elem_t b);
		send_cmd(op, a, b);
		@(posedge clk);
		#1;
		@(posedge clk);
		#1;
		cmd_valid = 1'b1;
		cmd.op = gf_op_pkg::op_mul;
		cmd.a = ~a;
		cmd.b = ~b;
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
		wait_for_done();
		repeat (gf_field_pkg::gf_m + 1) @(posedge clk); // No done may follow the op in flight.
		#1;
	endtask

	task automatic run_random(input gf_op_pkg::gf_op_t op);
		gf_field_pkg::gf_elem_t a;
		gf_field_pkg::gf_elem_t b;
		for (int k = 0; k < n_rand; k++) begin
			a = (k == 0) ? '0 : (k == 1) ? gf_field_pkg::gf_elem_t'(1) : rand_elem();
			b = (k == 2) ? '0 : (k == 3) ? gf_field_pkg::gf_elem_t'(1) : rand_elem();
			if (op == gf_op_pkg::op_div && b == '0) begin
				b = gf_field_pkg::gf_elem_t'(k); // Zero divisors have their own test.
			end
			if (op == gf_op_pkg::op_smul) begin
				run_cmd(gf_op_pkg::op_mul, a, b); // Same operands on the parallel unit.
			end
			run_cmd(op, a, b);
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors) begin
			pass_count++;
			$display("%0d ns: %s ok", $time, name);
		end else begin
			fail_count++;
			$display("%0d ns: %s FAILED with %0d errors", $time, name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	initial begin
		seed = 78958;
		errors = 0;
		test_errors = 0;
		pass_count = 0;
		fail_count = 0;
		exp_lat = 1;
		started = 1'b0;
		expect_done = 1'b0;
		chk_div = 1'b0;
		exp_zero = 1'b0;
		exp_value = '0;
		cur_a = '0;
		cur_b = '0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;

		repeat (4) @(posedge clk);
		#1;
		end_test("reset");

		run_random(gf_op_pkg::op_mul);
		end_test("mul");
		run_random(gf_op_pkg::op_sqr);
		end_test("sqr");
		run_random(gf_op_pkg::op_cube);
		end_test("cube");
		run_random(gf_op_pkg::op_smul);
		end_test("smul");
		run_random(gf_op_pkg::op_div);
		end_test("div");

		run_cmd(gf_op_pkg::op_div, '0, '0);
		run_cmd(gf_op_pkg::op_div, gf_field_pkg::gf_elem_t'(1), '0);
		run_cmd(gf_op_pkg::op_div, rand_elem(), '0);
		run_cmd(gf_op_pkg::op_div, rand_elem(), '0);
		end_test("div_zero");

		run_with_stray(gf_op_pkg::op_smul, rand_elem(), rand_elem());
		run_with_stray(gf_op_pkg::op_smul, rand_elem(), rand_elem());
		run_with_stray(gf_op_pkg::op_div, rand_elem(), rand_elem());
		run_with_stray(gf_op_pkg::op_div, rand_elem(), rand_elem());
		end_test("busy");

		$display("Summary: %0d ok, %0d failing, %0d errors", pass_count, fail_count, errors);
		if (fail_count == 0 && errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== gf_alu.f ====
+incdir+dv
rtl/gf_field_pkg.sv
rtl/gf_op_pkg.sv
rtl/gf_standard_mult.sv
rtl/gf_power.sv
rtl/gf_dual_mult.sv
rtl/gf_serial_mult.sv
rtl/gf_divider.sv
rtl/gf_alu.sv
dv/gf_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the gf_alu testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module gf_alu_tb \
	-f gf_alu.f -o gf_alu_sim || exit 1
./obj_dir/gf_alu_sim > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
